//--- priv_defs.svh
`ifndef PRIV_DEFS_SVH
`define PRIV_DEFS_SVH

`define PRIV_XLEN   32
`define CSR_AW      14
`define EXP_W       7
`define INVTLB_OP_W 3

// csr addresses
`define CSR_CRMD    14'h0
`define CSR_PRMD    14'h1
`define CSR_ERA     14'h6
`define CSR_SAVE0   14'h30

// csr op class, taken from the rj field
`define CSR_OP_RD   5'd0
`define CSR_OP_WR   5'd1

// tlb sub-op, inst[11:10]
`define TLB_OP_WR   2'b00
`define TLB_OP_FILL 2'b01
`define TLB_OP_SRCH 2'b10
`define TLB_OP_RD   2'b11

// cacop target, code[1:0]
`define CACHE_L1I   2'd0
`define CACHE_L1D   2'd1

`endif

//--- priv_pkg.sv
`include "priv_defs.svh"

package priv_pkg;

    // one instruction word, two decodes
    typedef union packed {
        struct packed {
            logic [7:0]         opcode;
            logic [`CSR_AW-1:0] csr_num;
            logic [4:0]         rj_sel;   // 0 csrrd, 1 csrwr, else csrxchg
            logic [4:0]         rd;
        } csr_view;
        struct packed {
            logic [14:0] opcode;
            logic        inv_flag;        // invtlb
            logic [3:0]  spare;
            logic [1:0]  tlb_op;
            logic [4:0]  rk_sel;
            logic [4:0]  code;            // cacop code or invtlb op
        } cop_view;
    } priv_inst_u;

endpackage

//--- priv_ctrl.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module priv_ctrl import priv_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en_in,
    input  logic                  is_csr,
    input  logic                  is_tlb,
    input  logic                  is_cache,
    input  logic                  is_idle,
    input  logic                  is_ertn,
    input  priv_inst_u            inst,
    input  logic [`PRIV_XLEN-1:0] pc_next,
    input  logic [`PRIV_XLEN-1:0] era,
    input  logic [4:0]            addr_in,
    input  logic                  icache_idle,
    input  logic                  dcache_idle,
    input  logic                  cop_done,
    output logic                  csr_go,
    output logic                  ertn_go,
    output logic                  tlb_go,
    output logic                  tlb_fire,
    output logic                  cop_go,
    output logic                  en_out,
    output logic                  flush,
    output logic                  stall_because_priv,
    output logic [`PRIV_XLEN-1:0] pc_target,
    output logic [4:0]            addr_out,
    output logic                  clear_clock_gate_require,
    output logic                  clear_clock_gate,
    output logic                  srch_en,
    output logic                  rd_en,
    output logic                  wr_en,
    output logic                  fill_en,
    output logic                  inv_en
);
    // one-hot state bit positions
    localparam int S_INIT      = 0;
    localparam int S_CSR       = 1;
    localparam int S_ERTN      = 2;
    localparam int S_TLB       = 3;
    localparam int S_TLB_FIRE  = 4;
    localparam int S_CACOP     = 5;
    localparam int S_IDLE      = 6;
    localparam int S_IDLE_W1   = 7;
    localparam int S_IDLE_W2   = 8;
    localparam int S_IDLE_SYNC = 9;
    localparam int S_IDLE_PERF = 10;
    localparam int S_DONE      = 11;
    localparam int NSTATE      = 12;

    logic [NSTATE-1:0] state;
    logic [NSTATE-1:0] next_state;
    logic              accept;
    logic              caches_idle;

    assign accept      = en_in & state[S_INIT] & (is_csr | is_tlb | is_cache | is_idle | is_ertn);
    assign caches_idle = icache_idle & dcache_idle;

    assign csr_go   = accept & is_csr;
    assign ertn_go  = accept & is_ertn;
    assign tlb_go   = accept & is_tlb;
    assign cop_go   = accept & is_cache;
    assign tlb_fire = state[S_TLB_FIRE];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= '0;
            state[S_INIT] <= 1'b1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = '0;
        unique case (1'b1)
            state[S_INIT]: begin
                next_state[S_INIT]  = !accept;
                next_state[S_CSR]   = accept & is_csr;
                next_state[S_ERTN]  = accept & is_ertn;
                next_state[S_TLB]   = accept & is_tlb;
                next_state[S_CACOP] = accept & is_cache;
                next_state[S_IDLE]  = accept & is_idle;
            end
            state[S_CSR], state[S_ERTN], state[S_TLB_FIRE]:
                next_state[S_DONE] = 1'b1;
            state[S_TLB]:       next_state[S_TLB_FIRE] = 1'b1;
            state[S_CACOP]: begin
                next_state[S_DONE]  = cop_done;
                next_state[S_CACOP] = !cop_done;   // held by cache back-pressure
            end
            state[S_IDLE]:      next_state[S_IDLE_W1] = 1'b1;
            state[S_IDLE_W1]:   next_state[S_IDLE_W2] = 1'b1;
            state[S_IDLE_W2]: begin
                next_state[S_IDLE_SYNC] = caches_idle;
                next_state[S_IDLE_W2]   = !caches_idle;
            end
            state[S_IDLE_SYNC]: next_state[S_IDLE_PERF] = 1'b1;
            state[S_IDLE_PERF]: next_state[S_DONE] = 1'b1;
            default:            next_state[S_INIT] = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_out                   <= 1'b0;
            flush                    <= 1'b0;
            stall_because_priv       <= 1'b0;
            clear_clock_gate         <= 1'b0;
            clear_clock_gate_require <= 1'b0;
        end else begin
            en_out             <= state[S_DONE];
            flush              <= state[S_DONE];
            stall_because_priv <= !state[S_INIT] & !state[S_DONE];
            clear_clock_gate   <= state[S_IDLE_PERF];   // single pulse
            if (accept & is_idle)
                clear_clock_gate_require <= 1'b1;
            else if (state[S_DONE])
                clear_clock_gate_require <= 1'b0;
        end
    end

    // operands kept for the completion pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_target <= is_ertn ? era : pc_next;
            addr_out  <= addr_in;
        end
        if (tlb_go) begin
            inv_en  <= inst.cop_view.inv_flag;
            srch_en <= !inst.cop_view.inv_flag & (inst.cop_view.tlb_op == `TLB_OP_SRCH);
            rd_en   <= !inst.cop_view.inv_flag & (inst.cop_view.tlb_op == `TLB_OP_RD);
            wr_en   <= !inst.cop_view.inv_flag & (inst.cop_view.tlb_op == `TLB_OP_WR);
            fill_en <= !inst.cop_view.inv_flag & (inst.cop_view.tlb_op == `TLB_OP_FILL);
        end
    end

endmodule

//--- csr_regfile.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module csr_regfile import priv_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  csr_go,
    input  logic                  ertn_go,
    input  priv_inst_u            inst,
    input  logic [`PRIV_XLEN-1:0] sr0,
    input  logic [`PRIV_XLEN-1:0] sr1,
    output logic [`PRIV_XLEN-1:0] result,
    output logic [`PRIV_XLEN-1:0] era
);
    logic [`PRIV_XLEN-1:0] crmd;
    logic [`PRIV_XLEN-1:0] prmd;
    logic [`PRIV_XLEN-1:0] save0;
    logic [`PRIV_XLEN-1:0] old_val;
    logic [`PRIV_XLEN-1:0] wmask;
    logic [`PRIV_XLEN-1:0] new_val;
    logic [`CSR_AW-1:0]    addr;

    assign addr = inst.csr_view.csr_num;

    always_comb begin
        case (addr)
            `CSR_CRMD:  old_val = crmd;
            `CSR_PRMD:  old_val = prmd;
            `CSR_ERA:   old_val = era;
            `CSR_SAVE0: old_val = save0;
            default:    old_val = '0;    // unimplemented csr
        endcase
    end

    always_comb begin
        case (inst.csr_view.rj_sel)
            `CSR_OP_RD: wmask = '0;
            `CSR_OP_WR: wmask = '1;
            default:    wmask = sr0;     // csrxchg
        endcase
    end

    assign new_val = (old_val & ~wmask) | (sr1 & wmask);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd  <= `PRIV_XLEN'h8;     // da set
            prmd  <= '0;
            era   <= '0;
            save0 <= '0;
        end else if (csr_go) begin
            case (addr)
                `CSR_CRMD:  crmd  <= new_val;
                `CSR_PRMD:  prmd  <= new_val;
                `CSR_ERA:   era   <= new_val;
                `CSR_SAVE0: save0 <= new_val;
                default:    ;
            endcase
        end else if (ertn_go) begin
            crmd[2:0] <= prmd[2:0];      // restore plv and ie
        end
    end

    always_ff @(posedge clk) begin
        if (csr_go)
            result <= old_val;
    end

endmodule

//--- tlb_cmd_unit.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module tlb_cmd_unit import priv_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    tlb_go,
    input  logic                    tlb_fire,
    input  logic                    srch_en,
    input  logic                    rd_en,
    input  logic                    wr_en,
    input  logic                    fill_en,
    input  logic                    inv_en,
    input  priv_inst_u              inst,
    input  logic [`PRIV_XLEN-1:0]   sr0,
    input  logic [`PRIV_XLEN-1:0]   sr1,
    output logic                    tlb_we,
    output logic                    tlb_index_we,
    output logic                    tlb_e_we,
    output logic                    tlb_other_we,
    output logic                    fill_mode,
    output logic                    check_mode,
    output logic [`PRIV_XLEN-1:0]   clear_vaddr,
    output logic [9:0]              clear_asid,
    output logic [`INVTLB_OP_W-1:0] clear_mem
);
    logic [4:0] inv_code;

    always_ff @(posedge clk) begin
        if (tlb_go) begin
            clear_asid  <= sr0[9:0];
            clear_vaddr <= sr1;
            inv_code    <= inst.cop_view.code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tlb_we       <= 1'b0;
            tlb_index_we <= 1'b0;
            tlb_e_we     <= 1'b0;
            tlb_other_we <= 1'b0;
            fill_mode    <= 1'b0;
            check_mode   <= 1'b0;
            clear_mem    <= '0;
        end else begin
            tlb_index_we <= tlb_fire & srch_en;
            tlb_e_we     <= tlb_fire & (srch_en | rd_en);
            tlb_other_we <= tlb_fire & rd_en;
            tlb_we       <= tlb_fire & (wr_en | fill_en);
            clear_mem    <= '0;
            if (tlb_fire & inv_en) begin
                // op 0 behaves as op 1
                clear_mem <= (inv_code == 5'd0) ? `INVTLB_OP_W'd1
                                                : inv_code[`INVTLB_OP_W-1:0];
            end
            if (tlb_fire & (srch_en | rd_en))
                check_mode <= srch_en;
            if (tlb_fire & (wr_en | fill_en))
                fill_mode <= fill_en;
        end
    end

endmodule

//--- cacop_req.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module cacop_req import priv_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cop_go,
    input  priv_inst_u            inst,
    input  logic [`PRIV_XLEN-1:0] sr0,
    input  logic [`PRIV_XLEN-1:0] imm,
    input  logic                  l1i_ready, l1d_ready, l2_ready,
    input  logic                  l1i_complete, l1d_complete, l2_complete,
    input  logic [`EXP_W-1:0]     cacop_iexp_in,
    input  logic [`EXP_W-1:0]     cacop_dexp_in,
    input  logic [`PRIV_XLEN-1:0] cacop_ibadv_in,
    input  logic [`PRIV_XLEN-1:0] cacop_dbadv_in,
    output logic                  cop_done,
    output logic                  l1i_en, l1d_en, l2_en,
    output logic                  use_tlb_s0, use_tlb_s1,
    output logic [1:0]            cacop_code,
    output logic [`PRIV_XLEN-1:0] cacop_rj_plus_imm,
    output logic [`EXP_W-1:0]     exp_out,
    output logic [`PRIV_XLEN-1:0] badv_out
);
    logic                  req;
    logic                  waiting;
    logic                  sel_i, sel_d, sel_2;
    logic                  ready;
    logic                  complete;
    logic [1:0]            hold;     // covers the done and en_out cycles
    logic [`EXP_W-1:0]     exp_q;
    logic [`PRIV_XLEN-1:0] badv_q;

    assign ready    = (sel_i & l1i_ready) | (sel_d & l1d_ready) | (sel_2 & l2_ready);
    assign complete = (sel_i & l1i_complete) | (sel_d & l1d_complete) | (sel_2 & l2_complete);
    assign cop_done = ((req & ready) | waiting) & complete;

    assign l1i_en     = req & sel_i;
    assign l1d_en     = req & sel_d;
    assign l2_en      = req & sel_2;
    assign use_tlb_s0 = (req | waiting) & sel_i;
    assign use_tlb_s1 = (req | waiting) & sel_d;

    assign exp_out  = (|hold) ? exp_q : '0;
    assign badv_out = (|hold) ? badv_q : '0;

    always_ff @(posedge clk) begin
        if (cop_go) begin
            sel_i             <= inst.cop_view.code[1:0] == `CACHE_L1I;
            sel_d             <= inst.cop_view.code[1:0] == `CACHE_L1D;
            sel_2             <= inst.cop_view.code[1];   // 2 and 3 go to l2
            cacop_code        <= inst.cop_view.code[4:3];
            cacop_rj_plus_imm <= sr0 + imm;
        end
        if (cop_done) begin
            exp_q  <= sel_i ? cacop_iexp_in : (sel_d ? cacop_dexp_in : '0);
            badv_q <= sel_i ? cacop_ibadv_in : (sel_d ? cacop_dbadv_in : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req     <= 1'b0;
            waiting <= 1'b0;
            hold    <= '0;
        end else begin
            hold <= {hold[0], cop_done};
            if (cop_go) begin
                req <= 1'b1;
            end else if (req & ready) begin
                req     <= 1'b0;
                waiting <= !complete;   // complete may lag ready
            end else if (waiting & complete) begin
                waiting <= 1'b0;
            end
        end
    end

endmodule

//--- priv_exec_top.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module priv_exec_top import priv_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    en_in,
    input  logic                    is_csr, is_tlb, is_cache, is_idle, is_ertn,
    input  priv_inst_u              inst,
    input  logic [`PRIV_XLEN-1:0]   pc_next,
    input  logic [`PRIV_XLEN-1:0]   sr0,
    input  logic [`PRIV_XLEN-1:0]   sr1,
    input  logic [4:0]              addr_in,
    input  logic [`PRIV_XLEN-1:0]   imm,
    output logic                    en_out,
    output logic                    flush,
    output logic                    stall_because_priv,
    output logic [`PRIV_XLEN-1:0]   pc_target,
    output logic [`PRIV_XLEN-1:0]   result,
    output logic [4:0]              addr_out,
    output logic [`EXP_W-1:0]       exp_out,
    output logic [`PRIV_XLEN-1:0]   badv_out,
    // cache side
    output logic                    l1i_en, l1d_en, l2_en,
    input  logic                    l1i_ready, l1d_ready, l2_ready,
    input  logic                    l1i_complete, l1d_complete, l2_complete,
    output logic [1:0]              cacop_code,
    output logic [`PRIV_XLEN-1:0]   cacop_rj_plus_imm,
    output logic                    use_tlb_s0, use_tlb_s1,
    input  logic [`EXP_W-1:0]       cacop_iexp_in,
    input  logic [`EXP_W-1:0]       cacop_dexp_in,
    input  logic [`PRIV_XLEN-1:0]   cacop_ibadv_in,
    input  logic [`PRIV_XLEN-1:0]   cacop_dbadv_in,
    // tlb side
    output logic                    tlb_we, tlb_index_we, tlb_e_we, tlb_other_we,
    output logic                    fill_mode,
    output logic                    check_mode,
    output logic [`PRIV_XLEN-1:0]   clear_vaddr,
    output logic [9:0]              clear_asid,
    output logic [`INVTLB_OP_W-1:0] clear_mem,
    // idle
    output logic                    clear_clock_gate_require,
    output logic                    clear_clock_gate,
    input  logic                    icache_idle, dcache_idle
);
    logic                  csr_go, ertn_go;
    logic                  tlb_go, tlb_fire;
    logic                  cop_go, cop_done;
    logic                  srch_en, rd_en, wr_en, fill_en, inv_en;
    logic [`PRIV_XLEN-1:0] era;

    priv_ctrl u_priv_ctrl (.*);

    csr_regfile u_csr_regfile (.*);

    tlb_cmd_unit u_tlb_cmd_unit (.*);

    cacop_req u_cacop_req (.*);

endmodule

//--- tb_priv_exec.sv
`timescale 1ns/10ps
`include "priv_defs.svh"

module tb_priv_exec import priv_pkg::*; ();
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 64;
    localparam int MAX_CYCLES      = N_TESTS * CYCLES_PER_TEST;
    localparam int K_CSR   = 0;
    localparam int K_TLB   = 1;
    localparam int K_CACHE = 2;
    localparam int K_IDLE  = 3;
    localparam int K_ERTN  = 4;

    logic clk, rstn, en_in;
    logic is_csr, is_tlb, is_cache, is_idle, is_ertn;
    priv_inst_u inst;
    logic [31:0] pc_next, sr0, sr1, imm;
    logic [4:0]  addr_in;
    logic        en_out, flush, stall_because_priv;
    logic [31:0] pc_target, result, badv_out;
    logic [4:0]  addr_out;
    logic [6:0]  exp_out;
    logic        l1i_en, l1d_en, l2_en;
    logic        l1i_ready, l1d_ready, l2_ready;
    logic        l1i_complete, l1d_complete, l2_complete;
    logic [1:0]  cacop_code;
    logic [31:0] cacop_rj_plus_imm;
    logic        use_tlb_s0, use_tlb_s1;
    logic [6:0]  cacop_iexp_in, cacop_dexp_in;
    logic [31:0] cacop_ibadv_in, cacop_dbadv_in;
    logic        tlb_we, tlb_index_we, tlb_e_we, tlb_other_we;
    logic        fill_mode, check_mode;
    logic [31:0] clear_vaddr;
    logic [9:0]  clear_asid;
    logic [2:0]  clear_mem;
    logic        clear_clock_gate_require, clear_clock_gate;
    logic        icache_idle, dcache_idle;

    int          cycle;
    int          issue_cycle;
    int          mismatches;
    int          failures;
    int          i;
    int unsigned seed_val;
    logic [31:0] crmd_m, prmd_m, era_m, save0_m;   // csr model
    logic [31:0] exp_pc;
    logic [4:0]  exp_addr;
    logic [13:0] csr_list [4];

    priv_exec_top u_priv_exec_top (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        mismatches++;
        $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at cycle %0d: %s", cycle, what);
    endtask

    // protocol rules that hold on every cycle
    assert property (@(posedge clk) disable iff (!rstn) !(stall_because_priv && en_out))
        else report_failure("stall and en_out are high together");
    assert property (@(posedge clk) disable iff (!rstn) en_out == flush)
        else report_failure("flush does not follow en_out");
    assert property (@(posedge clk) disable iff (!rstn) !(en_out && $past(en_out)))
        else report_failure("en_out is longer than one cycle");
    assert property (@(posedge clk) disable iff (!rstn) $onehot0({l1i_en, l1d_en, l2_en}))
        else report_failure("more than one cache en line is high");
    assert property (@(posedge clk) disable iff (!rstn)
                     clear_clock_gate |-> clear_clock_gate_require)
        else report_failure("clock-gate clear without a pending request");

    function automatic logic [31:0] model_read(input logic [13:0] a);
        case (a)
            `CSR_CRMD:  return crmd_m;
            `CSR_PRMD:  return prmd_m;
            `CSR_ERA:   return era_m;
            `CSR_SAVE0: return save0_m;
            default:    return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [13:0] a, input logic [31:0] v);
        case (a)
            `CSR_CRMD:  crmd_m  = v;
            `CSR_PRMD:  prmd_m  = v;
            `CSR_ERA:   era_m   = v;
            `CSR_SAVE0: save0_m = v;
            default:    ;
        endcase
    endtask

    // called on a falling edge, returns one cycle later
    task automatic issue(input int kind, input priv_inst_u word, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c);
        en_in    = 1'b1;
        is_csr   = (kind == K_CSR);
        is_tlb   = (kind == K_TLB);
        is_cache = (kind == K_CACHE);
        is_idle  = (kind == K_IDLE);
        is_ertn  = (kind == K_ERTN);
        inst     = word;
        sr0      = a;
        sr1      = b;
        imm      = c;
        pc_next  = $urandom;
        addr_in  = 5'($urandom);
        exp_pc   = (kind == K_ERTN) ? era_m : pc_next;
        exp_addr = addr_in;
        issue_cycle = cycle + 1;
        @(negedge clk);
        {en_in, is_csr, is_tlb, is_cache, is_idle, is_ertn} = 6'b0;
    endtask

    task automatic wait_done();
        while (!en_out)
            @(negedge clk);
    endtask

    task automatic completion_checks(input string name, input int lat_exp);
        int lat;
        lat = cycle - issue_cycle;
        if (lat_exp >= 0)
            assert (lat == lat_exp) else report_mismatch({name, " latency"}, lat_exp, lat);
        assert (pc_target == exp_pc) else report_mismatch({name, " pc_target"}, exp_pc, pc_target);
        assert (addr_out == exp_addr)
            else report_mismatch({name, " addr_out"}, 32'(exp_addr), 32'(addr_out));
    endtask

    task automatic csr_access(input string name, input logic [13:0] addr, input logic [4:0] rj,
                              input logic [31:0] mask, input logic [31:0] data);
        priv_inst_u  w;
        logic [31:0] old_v;
        logic [31:0] m;
        logic [31:0] new_v;
        w = '0;
        w.csr_view.csr_num = addr;
        w.csr_view.rj_sel  = rj;
        old_v = model_read(addr);
        m = (rj == 5'd0) ? 32'h0 : ((rj == 5'd1) ? 32'hffff_ffff : mask);
        new_v = (old_v & ~m) | (data & m);
        issue(K_CSR, w, mask, data, $urandom);
        wait_done();
        assert (result == old_v) else report_mismatch(name, old_v, result);
        completion_checks(name, 2);
        model_write(addr, new_v);
    endtask

    task automatic ertn_return();
        priv_inst_u w;
        w = '0;
        issue(K_ERTN, w, $urandom, $urandom, $urandom);
        wait_done();
        completion_checks("ertn", 2);
        crmd_m[2:0] = prmd_m[2:0];   // plv and ie come back from prmd
    endtask

    task automatic tlb_command(input string name, input logic inv, input logic [1:0] op,
                               input logic [4:0] code);
        priv_inst_u  w;
        logic [31:0] a, b;
        logic [3:0]  strobes, seen, exp_set;   // we, index, e, other
        logic [2:0]  mem_seen, mem_exp;
        logic        fm, cm;
        int          hits, hit_cycle;
        w = '0;
        w.cop_view.inv_flag = inv;
        w.cop_view.tlb_op   = op;
        w.cop_view.code     = code;
        a = $urandom;
        b = $urandom;
        if (inv)
            exp_set = 4'b0000;
        else if (op == `TLB_OP_SRCH)
            exp_set = 4'b0110;
        else if (op == `TLB_OP_RD)
            exp_set = 4'b0011;
        else
            exp_set = 4'b1000;
        mem_exp = inv ? ((code == 5'd0) ? 3'd1 : code[2:0]) : 3'd0;
        hits = 0;
        hit_cycle = 0;
        seen = '0;
        mem_seen = '0;
        fm = 1'b0;
        cm = 1'b0;
        issue(K_TLB, w, a, b, 32'h0);
        while (!en_out) begin
            strobes = {tlb_we, tlb_index_we, tlb_e_we, tlb_other_we};
            if (strobes != 4'b0 || clear_mem != 3'b0) begin
                hits++;
                hit_cycle = cycle;
                seen = strobes;
                mem_seen = clear_mem;
                fm = fill_mode;
                cm = check_mode;
            end
            @(negedge clk);
        end
        assert (hits == 1 && hit_cycle == cycle - 1)
            else report_failure($sformatf("%s strobes were not one cycle before en_out", name));
        assert (seen == exp_set) else report_mismatch({name, " strobes"}, 32'(exp_set), 32'(seen));
        assert (mem_seen == mem_exp)
            else report_mismatch({name, " clear_mem"}, 32'(mem_exp), 32'(mem_seen));
        assert ({tlb_we, tlb_index_we, tlb_e_we, tlb_other_we} == 4'b0)
            else report_failure($sformatf("%s strobes still high at en_out", name));
        if (!inv && (op == `TLB_OP_SRCH || op == `TLB_OP_RD))
            assert (cm == (op == `TLB_OP_SRCH))
                else report_mismatch({name, " check_mode"}, 32'(op == `TLB_OP_SRCH), 32'(cm));
        if (!inv && (op == `TLB_OP_WR || op == `TLB_OP_FILL))
            assert (fm == (op == `TLB_OP_FILL))
                else report_mismatch({name, " fill_mode"}, 32'(op == `TLB_OP_FILL), 32'(fm));
        if (inv) begin
            assert (clear_asid == a[9:0])
                else report_mismatch({name, " clear_asid"}, 32'(a[9:0]), 32'(clear_asid));
            assert (clear_vaddr == b) else report_mismatch({name, " clear_vaddr"}, b, clear_vaddr);
        end
        completion_checks(name, 3);
    endtask

    task automatic cacop_access(input string name, input logic [1:0] target,
                                input logic [1:0] cop_code);
        priv_inst_u  w;
        logic [31:0] a, c, exp_b;
        logic [6:0]  exp_e;
        logic [2:0]  sel_exp;   // l1i, l1d, l2
        int          rdly, cdly, k;
        w = '0;
        w.cop_view.code = {cop_code, 1'b0, target};
        a = $urandom;
        c = $urandom;
        cacop_iexp_in  = 7'($urandom);
        cacop_dexp_in  = 7'($urandom);
        cacop_ibadv_in = $urandom;
        cacop_dbadv_in = $urandom;
        sel_exp = (target == 2'd0) ? 3'b100 : ((target == 2'd1) ? 3'b010 : 3'b001);
        exp_e = (target == 2'd0) ? cacop_iexp_in : ((target == 2'd1) ? cacop_dexp_in : 7'h0);
        exp_b = (target == 2'd0) ? cacop_ibadv_in : ((target == 2'd1) ? cacop_dbadv_in : 32'h0);
        rdly = $urandom % 4;
        cdly = $urandom % 3;   // 0 means complete with ready
        issue(K_CACHE, w, a, 32'h0, c);
        assert (cacop_rj_plus_imm == a + c)
            else report_mismatch({name, " rj_plus_imm"}, a + c, cacop_rj_plus_imm);
        assert (cacop_code == cop_code)
            else report_mismatch({name, " cacop_code"}, 32'(cop_code), 32'(cacop_code));
        for (k = 0; k <= rdly; k++) begin
            assert ({l1i_en, l1d_en, l2_en} == sel_exp)
                else report_mismatch({name, " en lines"}, 32'(sel_exp),
                                     32'({l1i_en, l1d_en, l2_en}));
            // l1i looks up through tlb port s0, l1d through s1
            assert ({use_tlb_s0, use_tlb_s1} == sel_exp[2:1])
                else report_mismatch({name, " use_tlb"}, 32'(sel_exp[2:1]),
                                     32'({use_tlb_s0, use_tlb_s1}));
            if (k < rdly)
                @(negedge clk);
        end
        {l1i_ready, l1d_ready, l2_ready} = sel_exp;
        if (cdly == 0)
            {l1i_complete, l1d_complete, l2_complete} = sel_exp;
        @(negedge clk);
        {l1i_ready, l1d_ready, l2_ready} = 3'b0;
        assert ({l1i_en, l1d_en, l2_en} == 3'b0)
            else report_failure($sformatf("%s en line still high after ready", name));
        if (cdly > 0) begin
            repeat (cdly - 1) @(negedge clk);
            {l1i_complete, l1d_complete, l2_complete} = sel_exp;
            @(negedge clk);
        end
        {l1i_complete, l1d_complete, l2_complete} = 3'b0;
        wait_done();
        assert (exp_out == exp_e)
            else report_mismatch({name, " exp_out"}, 32'(exp_e), 32'(exp_out));
        assert (badv_out == exp_b) else report_mismatch({name, " badv_out"}, exp_b, badv_out);
        completion_checks(name, -1);
        @(negedge clk);
        assert (exp_out == 7'h0 && badv_out == 32'h0)
            else report_failure($sformatf("%s exception outputs not cleared", name));
    endtask

    task automatic idle_sequence(input string name);
        priv_inst_u w, w2;
        int         di, dd, m, k, cg_hits, cg_cycle;
        w  = '0;
        w2 = '0;
        w2.csr_view.csr_num = `CSR_SAVE0;
        w2.csr_view.rj_sel  = 5'd1;
        di = 3 + $urandom % 4;   // idle first seen in the wait state
        dd = 3 + $urandom % 4;
        m = (di > dd) ? di : dd;
        cg_hits = 0;
        cg_cycle = 0;
        issue(K_IDLE, w, 32'h0, 32'h0, 32'h0);
        k = 1;
        while (!en_out) begin
            assert (clear_clock_gate_require)
                else report_failure($sformatf("%s clock-gate request low during idle", name));
            if (clear_clock_gate) begin
                cg_hits++;
                cg_cycle = cycle;
            end
            if (k == 2) begin
                // issue attempt under stall, must be ignored
                assert (stall_because_priv)
                    else report_failure($sformatf("%s stall low during idle", name));
                en_in  = 1'b1;
                is_csr = 1'b1;
                inst   = w2;
                sr1    = $urandom;
            end else begin
                en_in  = 1'b0;
                is_csr = 1'b0;
            end
            icache_idle = (k >= di);
            dcache_idle = (k >= dd);
            @(negedge clk);
            k++;
        end
        assert (cg_hits == 1)
            else report_failure($sformatf("%s clock-gate clear pulsed %0d times", name, cg_hits));
        assert (cg_cycle == issue_cycle + m + 2)
            else report_mismatch({name, " clear cycle"}, issue_cycle + m + 2, cg_cycle);
        assert (cycle == cg_cycle + 1)
            else report_failure($sformatf("%s en_out did not follow the clear pulse", name));
        completion_checks(name, -1);
        icache_idle = 1'b0;
        dcache_idle = 1'b0;
        @(negedge clk);
        assert (!en_out && !stall_because_priv)
            else report_failure($sformatf("%s ignored issue was executed", name));
    endtask

    initial begin
        logic [11:0] quiet_vec;
        seed_val = $urandom(50742);
        clk = 1'b0;
        rstn = 1'b0;
        cycle = 0;
        mismatches = 0;
        failures = 0;
        {en_in, is_csr, is_tlb, is_cache, is_idle, is_ertn} = 6'b0;
        inst = '0;
        pc_next = 32'h0;
        sr0 = 32'h0;
        sr1 = 32'h0;
        imm = 32'h0;
        addr_in = 5'h0;
        {l1i_ready, l1d_ready, l2_ready} = 3'b0;
        {l1i_complete, l1d_complete, l2_complete} = 3'b0;
        cacop_iexp_in = 7'h0;
        cacop_dexp_in = 7'h0;
        cacop_ibadv_in = 32'h0;
        cacop_dbadv_in = 32'h0;
        icache_idle = 1'b0;
        dcache_idle = 1'b0;
        crmd_m = 32'h8;
        prmd_m = 32'h0;
        era_m = 32'h0;
        save0_m = 32'h0;
        csr_list = '{`CSR_CRMD, `CSR_PRMD, `CSR_ERA, `CSR_SAVE0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        repeat (2) begin
            quiet_vec = {stall_because_priv, en_out, flush, tlb_we, tlb_index_we, tlb_e_we,
                         tlb_other_we, l1i_en, l1d_en, l2_en, clear_clock_gate_require,
                         clear_clock_gate};
            assert (quiet_vec == 12'h0) else report_mismatch("reset outputs", 32'h0, 32'(quiet_vec));
            @(negedge clk);
        end

        for (i = 0; i < 4; i++) begin
            csr_access($sformatf("csrwr %h", csr_list[i]), csr_list[i], 5'd1, $urandom, $urandom);
            csr_access($sformatf("csrxchg %h", csr_list[i]), csr_list[i],
                       5'(2 + $urandom % 30), $urandom, $urandom);
            csr_access($sformatf("csrrd %h", csr_list[i]), csr_list[i], 5'd0, $urandom, $urandom);
        end
        csr_access("csrwr unmapped", 14'h5, 5'd1, $urandom, $urandom);
        csr_access("csrrd unmapped", 14'h5, 5'd0, $urandom, $urandom);

        // prmd low bits unlike crmd so the restore is visible
        csr_access("csrwr prmd", `CSR_PRMD, 5'd1, 32'h0, {29'($urandom), ~crmd_m[2:0]});
        csr_access("csrwr era", `CSR_ERA, 5'd1, 32'h0, $urandom);
        ertn_return();
        csr_access("csrrd crmd after ertn", `CSR_CRMD, 5'd0, 32'h0, 32'h0);

        tlb_command("tlbsrch", 1'b0, `TLB_OP_SRCH, 5'd0);
        tlb_command("tlbrd", 1'b0, `TLB_OP_RD, 5'd0);
        tlb_command("tlbwr", 1'b0, `TLB_OP_WR, 5'd0);
        tlb_command("tlbfill", 1'b0, `TLB_OP_FILL, 5'd0);
        tlb_command("invtlb op0", 1'b1, 2'b00, 5'd0);
        tlb_command("invtlb", 1'b1, 2'b00, 5'(1 + $urandom % 6));

        for (i = 0; i < 6; i++)
            cacop_access($sformatf("cacop target %0d", i % 4), 2'(i % 4), 2'($urandom));

        idle_sequence("idle a");
        idle_sequence("idle b");
        csr_access("csrrd save0 after idle", `CSR_SAVE0, 5'd0, 32'h0, 32'h0);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- priv_exec.f
+incdir+.
priv_pkg.sv
priv_ctrl.sv
csr_regfile.sv
tlb_cmd_unit.sv
cacop_req.sv
priv_exec_top.sv
tb_priv_exec.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f priv_exec.f --top-module tb_priv_exec -o tb_priv_exec_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_priv_exec_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
